// File: wrot.f
hdl/wrot_pkg.sv
hdl/wrot_bank_if.sv
hdl/wrot_loader.sv
hdl/wrot_bank_ram.sv
hdl/wrot_replayer.sv
hdl/axis_weight_rotator.sv
testbench/tb_wrot.sv

// File: Bender.yml
package:
  name: wrot

sources:
  - hdl/wrot_pkg.sv
  - hdl/wrot_bank_if.sv
  - hdl/wrot_loader.sv
  - hdl/wrot_bank_ram.sv
  - hdl/wrot_replayer.sv
  - hdl/axis_weight_rotator.sv
  - target: test
    files:
      - testbench/tb_wrot.sv

// File: testbench/tb_wrot.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wrot;

  logic                            aclk = 1'b0;
  logic                            rst_n;
  logic [wrot_pkg::BEAT_WIDTH-1:0] s_tdata;
  logic                            s_tvalid;
  logic                            s_tready;
  logic                            s_tlast;
  logic [wrot_pkg::BEAT_WIDTH-1:0] m_tdata;
  logic                            m_tvalid;
  logic                            m_tready;
  logic                            m_tlast;
  wrot_pkg::weight_user_t          m_tuser;

  // 0 holds m_tready low, 1 holds it high, 2 draws it at random every cycle
  logic [1:0] ready_mode;
  integer     seed = 32'h141d6a04;
  integer     rnd;
  string      test_name;

  logic [wrot_pkg::BEAT_WIDTH-1:0] exp_data [$];
  logic [1:0]                      exp_user [$];
  logic                            exp_last [$];
  logic [wrot_pkg::BEAT_WIDTH-1:0] d;
  logic [1:0]                      u;
  logic                            l;

  axis_weight_rotator dut (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tlast  (s_tlast),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tlast  (m_tlast),
    .m_tuser  (m_tuser)
  );

  initial begin
    forever #2 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    case (ready_mode)
      2'd0: m_tready <= 1'b0;
      2'd1: m_tready <= 1'b1;
      default: begin
        rnd = $random(seed);
        m_tready <= rnd[0];
      end
    endcase
  end

  task stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  // **************************************************************************
  // stimulus and reference model
  // **************************************************************************

  function automatic logic [wrot_pkg::BEAT_WIDTH-1:0] beat_pattern(input int pkt, input int idx);
    logic [15:0] word;
    word = {pkt[7:0], idx[7:0]};
    return {(wrot_pkg::BEAT_WIDTH / 16){word}};
  endfunction

  // kh_1 in bits 1:0, cin_1 in bits 5:2, reps_1 in bits 13:6
  function automatic logic [wrot_pkg::BEAT_WIDTH-1:0] config_beat(input int kh_1, input int cin_1,
                                                                  input int reps_1);
    logic [wrot_pkg::BEAT_WIDTH-1:0] b;
    b = '0;
    b[1:0]  = kh_1[1:0];
    b[5:2]  = cin_1[3:0];
    b[13:6] = reps_1[7:0];
    return b;
  endfunction

  task automatic expect_packet(input int pkt, input int kh_1, input int cin_1, input int reps_1);
    int rep;
    int row;
    int ch;
    for (rep = 0; rep <= reps_1; rep++) begin
      for (row = 0; row <= kh_1; row++) begin
        for (ch = 0; ch <= cin_1; ch++) begin
          exp_data.push_back(beat_pattern(pkt, row * (cin_1 + 1) + ch));
          exp_user.push_back({ch == cin_1, row == kh_1});
          exp_last.push_back((ch == cin_1) && (row == kh_1));
        end
      end
    end
  endtask

  // called right after a rising edge, returns right after the edge that took the beat
  task automatic send_beat(input logic [wrot_pkg::BEAT_WIDTH-1:0] data, input logic last);
    int waited;
    s_tdata  <= data;
    s_tvalid <= 1'b1;
    s_tlast  <= last;
    waited = 0;
    @(negedge aclk);
    while (!s_tready) begin
      waited++;
      if (waited > 1000) stop_on_error("input beat was never accepted by the DUT");
      @(negedge aclk);
    end
    @(posedge aclk);
  endtask

  task automatic send_packet(input int pkt, input int kh_1, input int cin_1, input int reps_1);
    int n;
    int i;
    n = (kh_1 + 1) * (cin_1 + 1);
    send_beat(config_beat(kh_1, cin_1, reps_1), 1'b0);
    for (i = 0; i < n; i++) begin
      send_beat(beat_pattern(pkt, i), i == n - 1);
    end
    s_tvalid <= 1'b0;
    s_tlast  <= 1'b0;
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    @(negedge aclk);
    while ((exp_data.size() != 0) || m_tvalid) begin
      waited++;
      if (waited > 4000) stop_on_error("expected output beats never left the DUT");
      @(negedge aclk);
    end
    @(posedge aclk);
  endtask

  // beats transfer on the next rising edge, so the monitor looks half a cycle earlier
  always @(negedge aclk) begin
    if (rst_n && m_tvalid && m_tready) begin
      assert (exp_data.size() != 0)
        else stop_on_error("DUT sent an output beat that was not expected");
      d = exp_data.pop_front();
      u = exp_user.pop_front();
      l = exp_last.pop_front();
      assert (m_tdata === d)
        else stop_on_error($sformatf("Fail %s: m_tdata expected %h actual %h",
                                     test_name, d, m_tdata));
      assert (m_tuser === u)
        else stop_on_error($sformatf("Fail %s: m_tuser expected %b actual %b",
                                     test_name, u, m_tuser));
      assert (m_tlast === l)
        else stop_on_error($sformatf("Fail %s: m_tlast expected %b actual %b",
                                     test_name, l, m_tlast));
    end
  end

  // **************************************************************************
  // directed tests
  // **************************************************************************

  task automatic test_reset_idle();
    int i;
    test_name = "test_reset_idle";
    for (i = 0; i < 20; i++) begin
      @(negedge aclk);
      assert (!m_tvalid)
        else stop_on_error($sformatf("Fail %s: m_tvalid expected 0 actual %b",
                                     test_name, m_tvalid));
      if (i >= 1) begin
        assert (s_tready)
          else stop_on_error($sformatf("Fail %s: s_tready expected 1 actual %b",
                                       test_name, s_tready));
      end
    end
    @(posedge aclk);
  endtask

  task automatic test_single_rep();
    test_name = "test_single_rep";
    ready_mode <= 2'd1;
    expect_packet(1, 2, 2, 0);
    send_packet(1, 2, 2, 0);
    wait_for_drain();
  endtask

  task automatic test_multi_rep();
    test_name = "test_multi_rep";
    expect_packet(2, 0, 3, 4);
    send_packet(2, 0, 3, 4);
    wait_for_drain();
  endtask

  task automatic test_backpressure();
    test_name = "test_backpressure";
    ready_mode <= 2'd2;
    expect_packet(3, 2, 2, 2);
    send_packet(3, 2, 2, 2);
    wait_for_drain();
  endtask

  task automatic test_ping_pong();
    test_name = "test_ping_pong";
    ready_mode <= 2'd0;
    expect_packet(4, 1, 1, 1);
    expect_packet(5, 2, 15, 0);
    expect_packet(6, 0, 0, 2);
    fork
      begin
        send_packet(4, 1, 1, 1);
        send_packet(5, 2, 15, 0);
        @(negedge aclk);
        assert (!s_tready)
          else stop_on_error($sformatf("Fail %s: s_tready expected 0 actual %b",
                                       test_name, s_tready));
        @(posedge aclk);
        send_packet(6, 0, 0, 2);
      end
      begin
        repeat (200) @(posedge aclk);
        ready_mode <= 2'd1;
      end
    join
    wait_for_drain();
  endtask

  initial begin
    rst_n      = 1'b0;
    s_tdata    = '0;
    s_tvalid   = 1'b0;
    s_tlast    = 1'b0;
    m_tready   = 1'b0;
    ready_mode = 2'd1;
    repeat (16) @(posedge aclk);
    rst_n <= 1'b1;
    test_reset_idle();
    test_single_rep();
    test_multi_rep();
    test_backpressure();
    test_ping_pong();
    if (exp_data.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      stop_on_error("expected output beats were left over at the end");
    end
  end

endmodule

`default_nettype wire

// File: hdl/axis_weight_rotator.sv
`timescale 1ns/1ps
`default_nettype none

module axis_weight_rotator (
  input  logic                            aclk,
  input  logic                            rst_n,
  input  logic [wrot_pkg::BEAT_WIDTH-1:0] s_tdata,
  input  logic                            s_tvalid,
  output logic                            s_tready,
  input  logic                            s_tlast,
  output logic [wrot_pkg::BEAT_WIDTH-1:0] m_tdata,
  output logic                            m_tvalid,
  input  logic                            m_tready,
  output logic                            m_tlast,
  output wrot_pkg::weight_user_t          m_tuser
);

  wrot_bank_if bank_if ();

  logic                            we;
  logic [wrot_pkg::ADDR_BITS-1:0]  waddr;
  logic [wrot_pkg::BEAT_WIDTH-1:0] wdata;
  logic [wrot_pkg::ADDR_BITS-1:0]  raddr;
  logic [wrot_pkg::BEAT_WIDTH-1:0] rdata;

  wrot_loader u_loader (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tlast  (s_tlast),
    .s_tready (s_tready),
    .we       (we),
    .waddr    (waddr),
    .wdata    (wdata),
    .bank     (bank_if.loader_mp)
  );

  wrot_bank_ram u_ram (
    .aclk  (aclk),
    .we    (we),
    .waddr (waddr),
    .wdata (wdata),
    .raddr (raddr),
    .rdata (rdata)
  );

  wrot_replayer u_replayer (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .bank     (bank_if.replayer_mp),
    .raddr    (raddr),
    .rdata    (rdata),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tlast  (m_tlast),
    .m_tuser  (m_tuser)
  );

endmodule

`default_nettype wire

// File: hdl/wrot_replayer.sv
`timescale 1ns/1ps
`default_nettype none

module wrot_replayer (
  input  logic                            aclk,
  input  logic                            rst_n,
  wrot_bank_if.replayer_mp                bank,
  output logic [wrot_pkg::ADDR_BITS-1:0]  raddr,
  input  logic [wrot_pkg::BEAT_WIDTH-1:0] rdata,
  output logic [wrot_pkg::BEAT_WIDTH-1:0] m_tdata,
  output logic                            m_tvalid,
  input  logic                            m_tready,
  output logic                            m_tlast,
  output wrot_pkg::weight_user_t          m_tuser
);

  wrot_pkg::play_state_e          state;
  logic                           cur;
  wrot_pkg::cfg_t                 cfg;
  logic [wrot_pkg::CIN_BITS-1:0]  ch;
  logic [wrot_pkg::KH_BITS-1:0]   row;
  logic [wrot_pkg::REPS_BITS-1:0] rep;
  logic [wrot_pkg::OFFS_BITS-1:0] offs;
  logic                           cin_last;
  logic                           kh_last;
  logic                           rep_last;
  logic                           fin;
  logic                           issue;
  logic                           pop;
  logic                           drain_done;
  logic [1:0]                     occ_next;

  logic                           rd_valid;
  logic                           rd_last;
  wrot_pkg::weight_user_t         rd_user;

  logic [wrot_pkg::BEAT_WIDTH-1:0] sk_data [2];
  logic                            sk_last [2];
  wrot_pkg::weight_user_t          sk_user [2];
  logic                            wr_ptr;
  logic                            rd_ptr;
  logic [1:0]                      count;

  // **************************************************************************
  // read address generation
  // **************************************************************************

  assign cfg      = bank.cfg[cur];
  assign cin_last = (ch == cfg.cin_1);
  assign kh_last  = (row == cfg.kh_1);
  assign rep_last = cin_last && kh_last;
  assign fin      = rep_last && (rep == cfg.reps_1);

  assign pop      = m_tvalid && m_tready;
  // skid occupancy after this edge, counting the read already in flight
  assign occ_next = count + {1'b0, rd_valid} - {1'b0, pop};
  assign issue    = (occ_next <= 2'd1) &&
                    ((state == wrot_pkg::PLAY_RUN) ||
                     ((state == wrot_pkg::PLAY_IDLE) && bank.full[cur]));
  assign raddr    = {cur, offs};

  assign drain_done = (state == wrot_pkg::PLAY_DRAIN) && pop &&
                      (count == 2'd1) && !rd_valid;

  assign bank.release_pulse = drain_done;
  assign bank.release_bank  = cur;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state <= wrot_pkg::PLAY_IDLE;
      cur   <= 1'b0;
      ch    <= '0;
      row   <= '0;
      rep   <= '0;
      offs  <= '0;
    end else if (issue) begin
      state <= fin ? wrot_pkg::PLAY_DRAIN : wrot_pkg::PLAY_RUN;
      ch    <= cin_last ? '0 : ch + 1'b1;
      offs  <= rep_last ? '0 : offs + 1'b1;
      if (cin_last) begin
        row <= kh_last ? '0 : row + 1'b1;
      end
      if (rep_last) begin
        rep <= fin ? '0 : rep + 1'b1;
      end
    end else if (drain_done) begin
      state <= wrot_pkg::PLAY_IDLE;
      cur   <= !cur;
    end
  end

  // flags follow the data through the one-cycle memory read
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= issue;
    end
  end

  always_ff @(posedge aclk) begin
    rd_last          <= rep_last;
    rd_user.cin_last <= cin_last;
    rd_user.kh_last  <= kh_last;
  end

  // **************************************************************************
  // two-entry skid buffer
  // **************************************************************************

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (rd_valid) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      count <= occ_next;
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_valid) begin
      sk_data[wr_ptr] <= rdata;
      sk_last[wr_ptr] <= rd_last;
      sk_user[wr_ptr] <= rd_user;
    end
  end

  assign m_tvalid = (count != 2'd0);
  assign m_tdata  = sk_data[rd_ptr];
  assign m_tlast  = sk_last[rd_ptr];
  assign m_tuser  = sk_user[rd_ptr];

  // a stalled beat must not change until the sink takes it
  assert property (@(posedge aclk) disable iff (!rst_n)
    m_tvalid && !m_tready
      |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast) && $stable(m_tuser));

endmodule

`default_nettype wire

// File: hdl/wrot_bank_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wrot_bank_ram (
  input  logic                            aclk,
  input  logic                            we,
  input  logic [wrot_pkg::ADDR_BITS-1:0]  waddr,
  input  logic [wrot_pkg::BEAT_WIDTH-1:0] wdata,
  input  logic [wrot_pkg::ADDR_BITS-1:0]  raddr,
  output logic [wrot_pkg::BEAT_WIDTH-1:0] rdata
);

  // top address bit picks the bank, the rest is the beat offset
  logic [wrot_pkg::BEAT_WIDTH-1:0] mem [2][wrot_pkg::BANK_DEPTH];

  always_ff @(posedge aclk) begin
    if (we) begin
      mem[waddr[wrot_pkg::ADDR_BITS-1]][waddr[wrot_pkg::OFFS_BITS-1:0]] <= wdata;
    end
  end

  // registered read keeps this a plain block RAM
  always_ff @(posedge aclk) begin
    rdata <= mem[raddr[wrot_pkg::ADDR_BITS-1]][raddr[wrot_pkg::OFFS_BITS-1:0]];
  end

endmodule

`default_nettype wire

// File: hdl/wrot_loader.sv
`timescale 1ns/1ps
`default_nettype none

module wrot_loader (
  input  logic                            aclk,
  input  logic                            rst_n,
  input  logic [wrot_pkg::BEAT_WIDTH-1:0] s_tdata,
  input  logic                            s_tvalid,
  input  logic                            s_tlast,
  output logic                            s_tready,
  output logic                            we,
  output logic [wrot_pkg::ADDR_BITS-1:0]  waddr,
  output logic [wrot_pkg::BEAT_WIDTH-1:0] wdata,
  wrot_bank_if.loader_mp                  bank
);

  wrot_pkg::load_state_e          state;
  logic                           wbank;
  logic [wrot_pkg::OFFS_BITS-1:0] wcnt;
  logic [wrot_pkg::CIN_BITS-1:0]  ch;
  logic [wrot_pkg::KH_BITS-1:0]   row;
  wrot_pkg::cfg_t                 cfg_in;
  wrot_pkg::cfg_t                 cfg_cur;
  logic                           take;
  logic                           last_beat;

  assign cfg_in    = wrot_pkg::cfg_t'(s_tdata[$bits(wrot_pkg::cfg_t)-1:0]);
  assign cfg_cur   = bank.cfg[wbank];
  assign s_tready  = (state != wrot_pkg::LOAD_WAIT_BANK);
  assign take      = s_tvalid && s_tready;
  assign last_beat = (ch == cfg_cur.cin_1) && (row == cfg_cur.kh_1);

  // weights go to the bank being filled, row-major with channel fastest
  assign we    = take && (state == wrot_pkg::LOAD_WEIGHTS);
  assign waddr = {wbank, wcnt};
  assign wdata = s_tdata;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state <= wrot_pkg::LOAD_WAIT_BANK;
      wbank <= 1'b0;
      wcnt  <= '0;
      ch    <= '0;
      row   <= '0;
    end else begin
      case (state)
        wrot_pkg::LOAD_WAIT_BANK: begin
          if (!bank.full[wbank]) begin
            state <= wrot_pkg::LOAD_CONFIG;
          end
        end
        wrot_pkg::LOAD_CONFIG: begin
          if (take) begin
            state <= wrot_pkg::LOAD_WEIGHTS;
            wcnt  <= '0;
            ch    <= '0;
            row   <= '0;
          end
        end
        wrot_pkg::LOAD_WEIGHTS: begin
          if (take) begin
            wcnt <= wcnt + 1'b1;
            if (ch == cfg_cur.cin_1) begin
              ch  <= '0;
              row <= row + 1'b1;
            end else begin
              ch <= ch + 1'b1;
            end
            if (last_beat) begin
              // switch banks, stalling if the replayer still owns the other one
              wbank <= !wbank;
              state <= bank.full[!wbank] ? wrot_pkg::LOAD_WAIT_BANK
                                         : wrot_pkg::LOAD_CONFIG;
            end
          end
        end
        default: state <= wrot_pkg::LOAD_WAIT_BANK;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if ((state == wrot_pkg::LOAD_CONFIG) && take) begin
      bank.cfg[wbank] <= cfg_in;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      bank.full <= 2'b00;
    end else begin
      if (bank.release_pulse) begin
        bank.full[bank.release_bank] <= 1'b0;
      end
      if (we && last_beat) begin
        bank.full[wbank] <= 1'b1;
      end
    end
  end

  // a config beat has to describe a weight set that fits one bank
  assert property (@(posedge aclk) disable iff (!rst_n)
    (state == wrot_pkg::LOAD_CONFIG) && take |-> (cfg_in.kh_1 < wrot_pkg::KH_MAX));

  // the sender's packet length has to agree with its own config beat
  assert property (@(posedge aclk) disable iff (!rst_n)
    take |-> (s_tlast == ((state == wrot_pkg::LOAD_WEIGHTS) && last_beat)));

endmodule

`default_nettype wire

// File: hdl/wrot_bank_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wrot_bank_if;

  // one full flag and one config per bank
  logic [1:0]     full;
  wrot_pkg::cfg_t cfg [2];

  // the replayer hands a drained bank back with a single-cycle pulse
  logic release_pulse;
  logic release_bank;

  modport loader_mp (
    output full,
    output cfg,
    input  release_pulse,
    input  release_bank
  );

  modport replayer_mp (
    input  full,
    input  cfg,
    output release_pulse,
    output release_bank
  );

endinterface

`default_nettype wire

// File: hdl/wrot_pkg.sv
`default_nettype none

package wrot_pkg;

  // **************************************************************************
  // buffer and stream sizes
  // **************************************************************************

  localparam int WORD_WIDTH = 8;
  localparam int CORES      = 4;
  localparam int KW_MAX     = 3;
  // kernel rows, kept odd
  localparam int KH_MAX     = 3;
  localparam int CIN_MAX    = 16;
  localparam int REPS_MAX   = 256;

  localparam int BEAT_WIDTH = WORD_WIDTH * CORES * KW_MAX;
  localparam int BANK_DEPTH = KH_MAX * CIN_MAX;
  localparam int OFFS_BITS  = $clog2(BANK_DEPTH);
  // one extra bit selects the bank
  localparam int ADDR_BITS  = OFFS_BITS + 1;

  localparam int KH_BITS    = $clog2(KH_MAX);
  localparam int CIN_BITS   = $clog2(CIN_MAX);
  localparam int REPS_BITS  = $clog2(REPS_MAX);

  // **************************************************************************
  // config beat and output sideband
  // **************************************************************************

  // kh_1 sits in the lowest bits of the config beat
  typedef struct packed {
    logic [REPS_BITS-1:0] reps_1;
    logic [CIN_BITS-1:0]  cin_1;
    logic [KH_BITS-1:0]   kh_1;
  } cfg_t;

  typedef struct packed {
    logic cin_last;
    logic kh_last;
  } weight_user_t;

  typedef enum logic [1:0] {
    LOAD_CONFIG,
    LOAD_WEIGHTS,
    LOAD_WAIT_BANK
  } load_state_e;

  typedef enum logic [1:0] {
    PLAY_IDLE,
    PLAY_RUN,
    PLAY_DRAIN
  } play_state_e;

endpackage

`default_nettype wire
